// ==== mmu_params.svh ====
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// ============================================================
// tlb geometry
// ============================================================
`define TLB_WAYS      4
`define TLB_SETS      16
`define TLB_SET_BITS  4

// address split, 4 kB pages
`define VADR_BITS     32
`define PADR_BITS     32
`define PAGE_BITS     12
// vpn bits above the set index
`define TAG_BITS      16
`define ASID_BITS     8

// ============================================================
// register word addresses
// ============================================================
`define REG_CTRL      4'd0
`define REG_ENTRY_HI  4'd1
`define REG_ENTRY_LO  4'd2
`define REG_INDEX     4'd3
`define REG_CMD       4'd4
`define REG_MISS_ADR  4'd5
`define REG_STATUS    4'd6

`endif

// ==== mmu_pkg.sv ====
`default_nettype none

`include "mmu_params.svh"

package mmu_pkg;

	// ============================================================
	// tlb entry, valid sits in the top bit
	// ============================================================
	typedef struct packed {
		logic                              valid;
		// global mapping, matches any asid
		logic                              g;
		logic [`ASID_BITS-1:0]             asid;
		logic [`TAG_BITS-1:0]              tag;
		logic [`PADR_BITS-`PAGE_BITS-1:0]  ppn;
		logic                              r;
		logic                              w;
		logic                              x;
		// user may access the page
		logic                              u;
		// accessed and dirty, set by the lookup side
		logic                              a;
		logic                              d;
	} tlb_entry_t;

	// codes written to REG_CMD
	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_READ  = 2'd2
	} tlb_cmd_e;

	// register block FSM, starts in the clear sweep
	typedef enum logic [1:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_RD_WAIT1,
		ST_RD_WAIT2
	} regs_state_e;

endpackage

`default_nettype wire

// ==== tlb_way_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_way_ram (
	input  wire                        clk_g,
	// port a, register side
	input  wire                        a_en_i,
	input  wire                        a_we_i,
	input  wire [`TLB_SET_BITS-1:0]    a_index_i,
	input  wire mmu_pkg::tlb_entry_t   a_wdata_i,
	output mmu_pkg::tlb_entry_t        a_rdata_o,
	// port b, lookup side
	input  wire                        b_en_i,
	input  wire                        b_we_i,
	input  wire [`TLB_SET_BITS-1:0]    b_index_i,
	input  wire mmu_pkg::tlb_entry_t   b_wdata_i,
	output mmu_pkg::tlb_entry_t        b_rdata_o
);
	import mmu_pkg::*;

	// one entry per set
	tlb_entry_t mem [`TLB_SETS];

	// port a is written last so it wins a same-set collision
	always_ff @(posedge clk_g) begin
		if (b_en_i && b_we_i)
			mem[b_index_i] <= b_wdata_i;
		if (a_en_i && a_we_i)
			mem[a_index_i] <= a_wdata_i;
	end

	// registered reads, old data on read during write
	always_ff @(posedge clk_g) begin
		if (a_en_i)
			a_rdata_o <= mem[a_index_i];
	end

	always_ff @(posedge clk_g) begin
		if (b_en_i)
			b_rdata_o <= mem[b_index_i];
	end

endmodule

`default_nettype wire

// ==== tlb_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_lookup (
	input  wire                                      clk_g,
	input  wire                                      rst_i,
	// request
	input  wire                                      req_valid_i,
	output logic                                     req_ready_o,
	input  wire [`VADR_BITS-1:0]                     vadr_i,
	input  wire                                      we_i,
	input  wire                                      user_i,
	// control from the register block
	input  wire                                      xlat_en_i,
	input  wire [`ASID_BITS-1:0]                     asid_i,
	input  wire                                      sweep_done_i,
	// port b of every way
	output logic                                     b_en_o,
	output logic [`TLB_WAYS-1:0]                     b_we_way_o,
	output logic [`TLB_SET_BITS-1:0]                 b_index_o,
	output mmu_pkg::tlb_entry_t                      b_wdata_o,
	input  wire mmu_pkg::tlb_entry_t [`TLB_WAYS-1:0] b_rdata_i,
	// result strobe
	output logic                                     rsp_valid_o,
	output logic [`PADR_BITS-1:0]                    padr_o,
	output logic [2:0]                               perm_o,
	output logic                                     miss_o,
	output logic                                     miss_pulse_o,
	output logic [`VADR_BITS-1:0]                    miss_vadr_o
);
	import mmu_pkg::*;

	localparam int WAY_BITS = $clog2(`TLB_WAYS);

	// stage 1, request fields while the ways are read
	logic                        s1_valid;
	logic [`VADR_BITS-1:0]       s1_vadr;
	logic                        s1_we;
	logic                        s1_user;
	logic                        s1_xlat;
	logic [`TLB_SET_BITS-1:0]    s1_set;
	logic [`TAG_BITS-1:0]        s1_tag;
	// stage 2, registered result
	logic                        s2_valid;
	logic                        s2_miss;
	logic [`VADR_BITS-1:0]       s2_vadr;
	logic [`PADR_BITS-1:0]       s2_padr;
	logic [2:0]                  s2_perm;
	// pending accessed/dirty write-back
	logic                        wb_pend;
	logic [WAY_BITS-1:0]         wb_way;
	logic [`TLB_SET_BITS-1:0]    wb_index;
	tlb_entry_t                  wb_entry;

	logic                        accept;
	tlb_entry_t [`TLB_WAYS-1:0]  way_data;
	logic                        hit;
	logic [WAY_BITS-1:0]         hit_way;
	tlb_entry_t                  hit_entry;
	logic                        wb_need;

	// the write-back cycle owns port b, so no new read then
	assign req_ready_o = sweep_done_i & ~wb_pend;
	assign accept      = req_valid_i & req_ready_o;

	assign b_en_o    = accept | wb_pend;
	assign b_index_o = wb_pend ? wb_index : vadr_i[`PAGE_BITS +: `TLB_SET_BITS];
	assign b_wdata_o = wb_entry;

	always_comb begin
		b_we_way_o = '0;
		if (wb_pend)
			b_we_way_o[wb_way] = 1'b1;
	end

	// ============================================================
	// tag compare over all ways
	// ============================================================
	assign s1_set = s1_vadr[`PAGE_BITS +: `TLB_SET_BITS];
	assign s1_tag = s1_vadr[`VADR_BITS-1 -: `TAG_BITS];

	// downward scan so the lowest matching way wins
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int i = `TLB_WAYS-1; i >= 0; i--) begin
			way_data[i] = b_rdata_i[i];
			// ram still holds the old copy of an entry being written back
			if (wb_pend && wb_way == WAY_BITS'(i) && wb_index == s1_set)
				way_data[i] = wb_entry;
			if (way_data[i].valid && way_data[i].tag == s1_tag &&
			    (way_data[i].g || way_data[i].asid == asid_i)) begin
				hit     = 1'b1;
				hit_way = WAY_BITS'(i);
			end
		end
		hit_entry = way_data[hit_way];
	end

	// first touch, or first write to a clean page
	assign wb_need = s1_valid & s1_xlat & hit & (~hit_entry.a | (s1_we & ~hit_entry.d));

	assign miss_pulse_o = s2_valid & s2_miss;
	assign miss_vadr_o  = s2_vadr;

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s1_valid    <= 1'b0;
			s2_valid    <= 1'b0;
			wb_pend     <= 1'b0;
			rsp_valid_o <= 1'b0;
			miss_o      <= 1'b0;
		end else begin
			s1_valid    <= accept;
			s2_valid    <= s1_valid;
			wb_pend     <= wb_need;
			rsp_valid_o <= s2_valid;
			miss_o      <= s2_valid & s2_miss;
		end
	end

	always_ff @(posedge clk_g) begin
		if (accept) begin
			s1_vadr <= vadr_i;
			s1_we   <= we_i;
			s1_user <= user_i;
			s1_xlat <= xlat_en_i;
		end
		s2_vadr <= s1_vadr;
		if (!s1_xlat) begin
			// untranslated, flat mapping with full access
			s2_padr <= s1_vadr;
			s2_perm <= 3'b111;
			s2_miss <= 1'b0;
		end else if (hit) begin
			s2_padr <= {hit_entry.ppn, s1_vadr[`PAGE_BITS-1:0]};
			// perm bit 0 read, bit 1 write, bit 2 execute
			s2_perm <= (s1_user && !hit_entry.u) ? 3'b000 :
			           {hit_entry.x, hit_entry.w, hit_entry.r};
			s2_miss <= 1'b0;
		end else begin
			s2_padr <= '0;
			s2_perm <= 3'b000;
			s2_miss <= 1'b1;
		end
		if (wb_need) begin
			wb_way     <= hit_way;
			wb_index   <= s1_set;
			wb_entry   <= hit_entry;
			wb_entry.a <= 1'b1;
			wb_entry.d <= hit_entry.d | s1_we;
		end
		padr_o <= s2_padr;
		perm_o <= s2_perm;
	end

endmodule

`default_nettype wire

// ==== mmu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_regs (
	input  wire                                      clk_g,
	input  wire                                      rst_i,
	// wishbone classic slave
	input  wire                                      wb_cyc_i,
	input  wire                                      wb_stb_i,
	input  wire                                      wb_we_i,
	input  wire [3:0]                                wb_adr_i,
	input  wire [31:0]                               wb_dat_i,
	output logic [31:0]                              wb_dat_o,
	output logic                                     wb_ack_o,
	// port a of every way
	output logic                                     a_en_o,
	output logic [`TLB_WAYS-1:0]                     a_we_way_o,
	output logic [`TLB_SET_BITS-1:0]                 a_index_o,
	output mmu_pkg::tlb_entry_t                      a_wdata_o,
	input  wire mmu_pkg::tlb_entry_t [`TLB_WAYS-1:0] a_rdata_i,
	// lookup control and miss capture
	output logic                                     xlat_en_o,
	output logic [`ASID_BITS-1:0]                    asid_o,
	output logic                                     sweep_done_o,
	input  wire                                      miss_pulse_i,
	input  wire [`VADR_BITS-1:0]                     miss_vadr_i
);
	import mmu_pkg::*;

	localparam int WAY_BITS = $clog2(`TLB_WAYS);
	localparam int SET_BITS = `TLB_SET_BITS;
	localparam logic [SET_BITS-1:0] LAST_SET = SET_BITS'(`TLB_SETS-1);

	regs_state_e               state;
	logic [SET_BITS-1:0]       sweep_cnt;
	// staging entry and table index
	tlb_entry_t                stage;
	logic [SET_BITS-1:0]       idx_set;
	logic [WAY_BITS-1:0]       idx_way;
	logic [`VADR_BITS-1:0]     miss_adr;

	logic                      wb_req;
	logic                      wr_req;
	tlb_cmd_e                  cmd;
	logic                      cmd_write;
	logic                      cmd_read;
	logic [31:0]               rd_data;

	assign sweep_done_o = (state != ST_SWEEP);

	// new access only in idle, ack cycle excluded
	assign wb_req    = wb_cyc_i & wb_stb_i & ~wb_ack_o & (state == ST_IDLE);
	assign wr_req    = wb_req & wb_we_i;
	assign cmd       = tlb_cmd_e'(wb_dat_i[1:0]);
	assign cmd_write = wr_req & (wb_adr_i == `REG_CMD) & (cmd == CMD_WRITE);
	assign cmd_read  = wr_req & (wb_adr_i == `REG_CMD) & (cmd == CMD_READ);

	// ============================================================
	// port a steering
	// ============================================================
	always_comb begin
		a_en_o     = 1'b0;
		a_we_way_o = '0;
		a_index_o  = idx_set;
		a_wdata_o  = stage;
		case (state)
			ST_SWEEP: begin
				// clear one set in every way
				a_en_o     = 1'b1;
				a_we_way_o = '1;
				a_index_o  = sweep_cnt;
				a_wdata_o  = '0;
			end
			ST_IDLE: begin
				// write lands on the ack edge
				if (cmd_write) begin
					a_en_o              = 1'b1;
					a_we_way_o[idx_way] = 1'b1;
				end
			end
			ST_RD_WAIT1: a_en_o = 1'b1;
			default: ;
		endcase
	end

	// register read mux
	always_comb begin
		rd_data = '0;
		case (wb_adr_i)
			`REG_CTRL: begin
				rd_data[0]              = xlat_en_o;
				rd_data[8 +: `ASID_BITS] = asid_o;
			end
			`REG_ENTRY_HI: begin
				rd_data[`TAG_BITS-1:0]    = stage.tag;
				rd_data[16 +: `ASID_BITS] = stage.asid;
				rd_data[24]               = stage.g;
				rd_data[25]               = stage.valid;
			end
			`REG_ENTRY_LO: begin
				rd_data[`PADR_BITS-`PAGE_BITS-1:0] = stage.ppn;
				rd_data[20] = stage.r;
				rd_data[21] = stage.w;
				rd_data[22] = stage.x;
				rd_data[23] = stage.u;
				rd_data[24] = stage.a;
				rd_data[25] = stage.d;
			end
			`REG_INDEX: begin
				rd_data[SET_BITS-1:0]   = idx_set;
				rd_data[8 +: WAY_BITS] = idx_way;
			end
			`REG_MISS_ADR: rd_data = miss_adr;
			`REG_STATUS: rd_data[0] = sweep_done_o;
			default: ;
		endcase
	end

	// ============================================================
	// FSM and control registers
	// ============================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			state     <= ST_SWEEP;
			sweep_cnt <= '0;
			wb_ack_o  <= 1'b0;
			xlat_en_o <= 1'b0;
			asid_o    <= '0;
		end else begin
			wb_ack_o <= 1'b0;
			case (state)
				ST_SWEEP: begin
					sweep_cnt <= sweep_cnt + 1'b1;
					if (sweep_cnt == LAST_SET)
						state <= ST_IDLE;
				end
				ST_IDLE: begin
					if (cmd_read) begin
						state <= ST_RD_WAIT1;
					end else if (wb_req) begin
						wb_ack_o <= 1'b1;
						if (wr_req && wb_adr_i == `REG_CTRL) begin
							xlat_en_o <= wb_dat_i[0];
							asid_o    <= wb_dat_i[8 +: `ASID_BITS];
						end
					end
				end
				// ram read issued here
				ST_RD_WAIT1: state <= ST_RD_WAIT2;
				// read data is in, ack with the staging load
				ST_RD_WAIT2: begin
					wb_ack_o <= 1'b1;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// staging, index and miss address
	always_ff @(posedge clk_g) begin
		if (miss_pulse_i)
			miss_adr <= miss_vadr_i;
		if (wb_req)
			wb_dat_o <= rd_data;
		if (wr_req) begin
			case (wb_adr_i)
				`REG_ENTRY_HI: begin
					stage.tag   <= wb_dat_i[`TAG_BITS-1:0];
					stage.asid  <= wb_dat_i[16 +: `ASID_BITS];
					stage.g     <= wb_dat_i[24];
					stage.valid <= wb_dat_i[25];
				end
				`REG_ENTRY_LO: begin
					stage.ppn <= wb_dat_i[`PADR_BITS-`PAGE_BITS-1:0];
					stage.r   <= wb_dat_i[20];
					stage.w   <= wb_dat_i[21];
					stage.x   <= wb_dat_i[22];
					stage.u   <= wb_dat_i[23];
					stage.a   <= wb_dat_i[24];
					stage.d   <= wb_dat_i[25];
				end
				`REG_INDEX: begin
					idx_set <= wb_dat_i[SET_BITS-1:0];
					idx_way <= wb_dat_i[8 +: WAY_BITS];
				end
				default: ;
			endcase
		end
		if (state == ST_RD_WAIT2)
			stage <= a_rdata_i[idx_way];
	end

endmodule

`default_nettype wire

// ==== mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_top (
	input  wire                      clk_g,
	input  wire                      rst_i,
	// wishbone register port
	input  wire                      wb_cyc_i,
	input  wire                      wb_stb_i,
	input  wire                      wb_we_i,
	input  wire [3:0]                wb_adr_i,
	input  wire [31:0]               wb_dat_i,
	output logic [31:0]              wb_dat_o,
	output logic                     wb_ack_o,
	// lookup request
	input  wire                      req_valid_i,
	output logic                     req_ready_o,
	input  wire [`VADR_BITS-1:0]     vadr_i,
	input  wire                      we_i,
	input  wire                      user_i,
	// lookup result
	output logic                     rsp_valid_o,
	output logic [`PADR_BITS-1:0]    padr_o,
	output logic [2:0]               perm_o,
	output logic                     miss_o
);
	import mmu_pkg::*;

	// ============================================================
	// port a, register side
	// ============================================================
	wire                             a_en;
	wire [`TLB_WAYS-1:0]             a_we_way;
	wire [`TLB_SET_BITS-1:0]         a_index;
	wire tlb_entry_t                 a_wdata;
	wire tlb_entry_t [`TLB_WAYS-1:0] a_rdata;
	// port b, lookup side
	wire                             b_en;
	wire [`TLB_WAYS-1:0]             b_we_way;
	wire [`TLB_SET_BITS-1:0]         b_index;
	wire tlb_entry_t                 b_wdata;
	wire tlb_entry_t [`TLB_WAYS-1:0] b_rdata;
	// regs and lookup cross signals
	wire                             xlat_en;
	wire [`ASID_BITS-1:0]            cur_asid;
	wire                             sweep_done;
	wire                             miss_pulse;
	wire [`VADR_BITS-1:0]            miss_vadr;

	mmu_regs i_mmu_regs (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.a_en_o       (a_en),
		.a_we_way_o   (a_we_way),
		.a_index_o    (a_index),
		.a_wdata_o    (a_wdata),
		.a_rdata_i    (a_rdata),
		.xlat_en_o    (xlat_en),
		.asid_o       (cur_asid),
		.sweep_done_o (sweep_done),
		.miss_pulse_i (miss_pulse),
		.miss_vadr_i  (miss_vadr)
	);

	tlb_lookup i_tlb_lookup (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.req_valid_i  (req_valid_i),
		.req_ready_o  (req_ready_o),
		.vadr_i       (vadr_i),
		.we_i         (we_i),
		.user_i       (user_i),
		.xlat_en_i    (xlat_en),
		.asid_i       (cur_asid),
		.sweep_done_i (sweep_done),
		.b_en_o       (b_en),
		.b_we_way_o   (b_we_way),
		.b_index_o    (b_index),
		.b_wdata_o    (b_wdata),
		.b_rdata_i    (b_rdata),
		.rsp_valid_o  (rsp_valid_o),
		.padr_o       (padr_o),
		.perm_o       (perm_o),
		.miss_o       (miss_o),
		.miss_pulse_o (miss_pulse),
		.miss_vadr_o  (miss_vadr)
	);

	// one ram per way, both ports shared across ways except write enables
	for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_way
		tlb_way_ram i_way_ram (
			.clk_g     (clk_g),
			.a_en_i    (a_en),
			.a_we_i    (a_we_way[w]),
			.a_index_i (a_index),
			.a_wdata_i (a_wdata),
			.a_rdata_o (a_rdata[w]),
			.b_en_i    (b_en),
			.b_we_i    (b_we_way[w]),
			.b_index_i (b_index),
			.b_wdata_i (b_wdata),
			.b_rdata_o (b_rdata[w])
		);
	end

endmodule

`default_nettype wire

// ==== tb_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tb_mmu;
	import mmu_pkg::*;

	localparam int WB_TIMEOUT  = 64;
	localparam int REQ_TIMEOUT = 64;
	localparam int RSP_TIMEOUT = 16;

	logic        clk_g;
	logic        rst;
	// wishbone master side
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [31:0] wb_wdat;
	logic [31:0] wb_rdat;
	logic        wb_ack;
	// lookup request and result
	logic        req_valid;
	logic        req_ready;
	logic [31:0] req_vadr;
	logic        req_we;
	logic        req_user;
	logic        rsp_valid;
	logic [31:0] padr;
	logic [2:0]  perm;
	logic        miss;

	// reference copy of the table, register word layout
	logic [31:0] hi_m [`TLB_WAYS][`TLB_SETS];
	logic [31:0] lo_m [`TLB_WAYS][`TLB_SETS];
	logic        xlat_on;
	logic [7:0]  cur_asid;
	// tag of the page mapped in each set
	logic [15:0] page_tag [`TLB_SETS];
	// request list for the back to back run
	logic [31:0] burst_vadr [8];
	logic        burst_we [8];
	logic        burst_user [8];

	mmu_top i_mmu_top (
		.clk_g       (clk_g),
		.rst_i       (rst),
		.wb_cyc_i    (wb_cyc),
		.wb_stb_i    (wb_stb),
		.wb_we_i     (wb_we),
		.wb_adr_i    (wb_adr),
		.wb_dat_i    (wb_wdat),
		.wb_dat_o    (wb_rdat),
		.wb_ack_o    (wb_ack),
		.req_valid_i (req_valid),
		.req_ready_o (req_ready),
		.vadr_i      (req_vadr),
		.we_i        (req_we),
		.user_i      (req_user),
		.rsp_valid_o (rsp_valid),
		.padr_o      (padr),
		.perm_o      (perm),
		.miss_o      (miss)
	);

	always #50 clk_g = ~clk_g;

	// ============================================================
	// failure reporting and compare
	// ============================================================
	task automatic report_fail(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_fail($sformatf("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	// ============================================================
	// bus drivers, entered and left on a falling edge
	// ============================================================
	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
		int cnt;
		cnt     = 0;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = 1'b1;
		wb_adr  = adr;
		wb_wdat = dat;
		@(negedge clk_g);
		while (!wb_ack) begin
			if (cnt == WB_TIMEOUT)
				report_fail($sformatf("timeout, no wishbone ack on write to register %0d", adr));
			cnt++;
			@(negedge clk_g);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
		int cnt;
		cnt    = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		@(negedge clk_g);
		while (!wb_ack) begin
			if (cnt == WB_TIMEOUT)
				report_fail($sformatf("timeout, no wishbone ack on read of register %0d", adr));
			cnt++;
			@(negedge clk_g);
		end
		dat    = wb_rdat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// one request, result expected two edges after the accepting edge
	task automatic lookup(input logic [31:0] vadr, input logic we, input logic user,
			output logic [31:0] padr_r, output logic [2:0] perm_r, output logic miss_r);
		int cnt;
		int lat;
		cnt       = 0;
		req_valid = 1'b1;
		req_vadr  = vadr;
		req_we    = we;
		req_user  = user;
		while (!req_ready) begin
			if (cnt == REQ_TIMEOUT)
				report_fail("timeout, lookup request was never accepted");
			cnt++;
			@(negedge clk_g);
		end
		// accepted on the next rising edge
		@(negedge clk_g);
		req_valid = 1'b0;
		// half a cycle past the accepting edge, no edge counted yet
		lat       = 0;
		while (!rsp_valid) begin
			if (lat == RSP_TIMEOUT)
				report_fail("timeout, no lookup result came back");
			lat++;
			@(negedge clk_g);
		end
		check("rsp_valid_o latency", lat, 2);
		padr_r = padr;
		perm_r = perm;
		miss_r = miss;
	endtask

	// ============================================================
	// table helpers and expected translation
	// ============================================================
	function automatic logic [31:0] make_hi(input logic [15:0] tag, input logic [7:0] asid,
			input logic g, input logic v);
		return {6'b0, v, g, asid, tag};
	endfunction

	// xwr is {x, w, r}
	function automatic logic [31:0] make_lo(input logic [19:0] ppn, input logic [2:0] xwr,
			input logic u, input logic a, input logic d);
		return {6'b0, d, a, u, xwr, ppn};
	endfunction

	function automatic logic [31:0] vadr_of(input int set, input logic [11:0] ofs);
		return {page_tag[set], 4'(set), ofs};
	endfunction

	// returns {miss, perm, padr}
	function automatic logic [35:0] predict(input logic [31:0] vadr, input logic user);
		logic [3:0]  set;
		logic [31:0] hi;
		logic [31:0] lo;
		logic [2:0]  p;
		set = vadr[15:12];
		if (!xlat_on)
			return {1'b0, 3'b111, vadr};
		for (int w = 0; w < `TLB_WAYS; w++) begin
			hi = hi_m[w][set];
			lo = lo_m[w][set];
			if (hi[25] && hi[15:0] == vadr[31:16] && (hi[24] || hi[23:16] == cur_asid)) begin
				p = (user && !lo[23]) ? 3'b000 : lo[22:20];
				return {1'b0, p, lo[19:0], vadr[11:0]};
			end
		end
		return {1'b1, 3'b000, 32'h0};
	endfunction

	task automatic map_page(input int way, input int set, input logic [31:0] hi,
			input logic [31:0] lo);
		wb_write(`REG_ENTRY_HI, hi);
		wb_write(`REG_ENTRY_LO, lo);
		wb_write(`REG_INDEX, 32'(way * 256 + set));
		wb_write(`REG_CMD, 32'(CMD_WRITE));
		hi_m[way][set] = hi;
		lo_m[way][set] = lo;
	endtask

	task automatic read_entry(input int way, input int set, output logic [31:0] hi,
			output logic [31:0] lo);
		wb_write(`REG_INDEX, 32'(way * 256 + set));
		wb_write(`REG_CMD, 32'(CMD_READ));
		wb_read(`REG_ENTRY_HI, hi);
		wb_read(`REG_ENTRY_LO, lo);
	endtask

	task automatic check_xlat(input logic [31:0] vadr, input logic we, input logic user);
		logic [31:0] padr_r;
		logic [2:0]  perm_r;
		logic        miss_r;
		logic [35:0] exp;
		exp = predict(vadr, user);
		lookup(vadr, we, user, padr_r, perm_r, miss_r);
		check("padr_o", padr_r, exp[31:0]);
		check("perm_o", perm_r, exp[34:32]);
		check("miss_o", miss_r, exp[35]);
	endtask

	// ============================================================
	// directed tests
	// ============================================================
	task automatic sweep_and_flat();
		logic [31:0] st;
		// held until the clear sweep is over
		wb_read(`REG_STATUS, st);
		check("status sweep_done", st[0], 1'b1);
		check_xlat($urandom(), 1'b0, 1'b0);
		check_xlat($urandom(), 1'b1, 1'b1);
	endtask

	task automatic entry_readback();
		logic [31:0] hi_w [8];
		logic [31:0] lo_w [8];
		logic [31:0] hi_r;
		logic [31:0] lo_r;
		for (int k = 0; k < 8; k++) begin
			hi_w[k] = $urandom() & 32'h03ff_ffff;
			lo_w[k] = $urandom() & 32'h03ff_ffff;
			map_page(k % 4, 2 * k, hi_w[k], lo_w[k]);
		end
		for (int k = 0; k < 8; k++) begin
			read_entry(k % 4, 2 * k, hi_r, lo_r);
			check("entry_hi", hi_r, hi_w[k]);
			check("entry_lo", lo_r, lo_w[k]);
		end
		// invalidate them again
		for (int k = 0; k < 8; k++)
			map_page(k % 4, 2 * k, 32'h0, 32'h0);
	endtask

	task automatic hit_perm();
		logic [7:0] other;
		cur_asid = $urandom();
		other    = cur_asid ^ 8'h5a;
		xlat_on  = 1'b1;
		wb_write(`REG_CTRL, {16'h0, cur_asid, 7'h0, 1'b1});
		for (int s = 0; s < 4; s++)
			page_tag[s] = $urandom();
		// own asid user page, supervisor only page, global page, foreign asid
		map_page(0, 0, make_hi(page_tag[0], cur_asid, 1'b0, 1'b1),
			make_lo($urandom(), 3'($urandom_range(1, 7)), 1'b1, 1'b1, 1'b1));
		map_page(1, 1, make_hi(page_tag[1], cur_asid, 1'b0, 1'b1),
			make_lo($urandom(), 3'($urandom_range(1, 7)), 1'b0, 1'b1, 1'b1));
		map_page(2, 2, make_hi(page_tag[2], other, 1'b1, 1'b1),
			make_lo($urandom(), 3'($urandom_range(1, 7)), 1'b1, 1'b1, 1'b1));
		map_page(3, 3, make_hi(page_tag[3], other, 1'b0, 1'b1),
			make_lo($urandom(), 3'($urandom_range(1, 7)), 1'b1, 1'b1, 1'b1));
		for (int s = 0; s < 4; s++) begin
			check_xlat(vadr_of(s, $urandom()), 1'b0, 1'b0);
			check_xlat(vadr_of(s, $urandom()), 1'b1, 1'b1);
		end
	endtask

	task automatic miss_capture();
		logic [31:0] vadr;
		logic [31:0] rd;
		// nothing valid lives in set 5
		vadr = {16'($urandom()), 4'd5, 12'($urandom())};
		check_xlat(vadr, 1'b0, 1'b0);
		wb_read(`REG_MISS_ADR, rd);
		check("miss_adr", rd, vadr);
	endtask

	task automatic access_dirty();
		logic [31:0] vadr;
		logic [31:0] lo0;
		logic [31:0] hi_r;
		logic [31:0] lo_r;
		page_tag[6] = $urandom();
		vadr        = vadr_of(6, $urandom());
		lo0         = make_lo($urandom(), 3'b111, 1'b1, 1'b0, 1'b0);
		map_page(1, 6, make_hi(page_tag[6], cur_asid, 1'b0, 1'b1), lo0);
		check_xlat(vadr, 1'b0, 1'b0);
		read_entry(1, 6, hi_r, lo_r);
		check("entry_lo after read hit", lo_r, lo0 | 32'h0100_0000);
		check_xlat(vadr, 1'b1, 1'b0);
		read_entry(1, 6, hi_r, lo_r);
		check("entry_lo after write hit", lo_r, lo0 | 32'h0300_0000);
	endtask

	// valid stays high, the next request goes out once one is taken
	task automatic lookup_burst(input int n);
		int          sent;
		int          got;
		int          idle;
		logic        take;
		logic [35:0] exp;
		sent      = 0;
		got       = 0;
		idle      = 0;
		req_valid = 1'b1;
		req_vadr  = burst_vadr[0];
		req_we    = burst_we[0];
		req_user  = burst_user[0];
		while (got < n) begin
			take = req_valid & req_ready;
			@(negedge clk_g);
			if (take) begin
				sent++;
				if (sent < n) begin
					req_vadr = burst_vadr[sent];
					req_we   = burst_we[sent];
					req_user = burst_user[sent];
				end else begin
					req_valid = 1'b0;
				end
			end
			if (rsp_valid) begin
				exp = predict(burst_vadr[got], burst_user[got]);
				check("padr_o", padr, exp[31:0]);
				check("perm_o", perm, exp[34:32]);
				check("miss_o", miss, exp[35]);
				got++;
				idle = 0;
			end else begin
				if (idle == RSP_TIMEOUT)
					report_fail("timeout, back to back results stopped coming");
				idle++;
			end
		end
	endtask

	task automatic back_to_back();
		int sets [7];
		sets = '{0, 1, 2, 3, 6, 0, 2};
		for (int k = 0; k < 7; k++) begin
			burst_vadr[k] = vadr_of(sets[k], $urandom());
			burst_user[k] = 1'($urandom());
			burst_we[k]   = 1'($urandom());
		end
		lookup_burst(7);
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		clk_g     = 1'b0;
		rst       = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_wdat   = '0;
		req_valid = 1'b0;
		req_vadr  = '0;
		req_we    = 1'b0;
		req_user  = 1'b0;
		xlat_on   = 1'b0;
		cur_asid  = '0;
		for (int w = 0; w < `TLB_WAYS; w++) begin
			for (int s = 0; s < `TLB_SETS; s++) begin
				hi_m[w][s] = '0;
				lo_m[w][s] = '0;
			end
		end
		for (int s = 0; s < `TLB_SETS; s++)
			page_tag[s] = '0;
		void'($urandom(32'h029b1e5a));
		repeat (5) @(posedge clk_g);
		@(negedge clk_g);
		rst = 1'b0;

		sweep_and_flat();
		entry_readback();
		hit_perm();
		miss_capture();
		access_dirty();
		back_to_back();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mmu_pkg.sv
tlb_way_ram.sv
tlb_lookup.sv
mmu_regs.sv
mmu_top.sv
tb_mmu.sv

// ==== Bender.yml ====
package:
  name: mmu

export_include_dirs:
  - .

sources:
  - mmu_pkg.sv
  - tlb_way_ram.sv
  - tlb_lookup.sv
  - mmu_regs.sv
  - mmu_top.sv
  - target: test
    files:
      - tb_mmu.sv
